// File: vlog.f
+incdir+include
hw/pcie_axil_pkg.sv
hw/sync_fifo.sv
hw/cq_request_decoder.sv
hw/axil_master.sv
hw/completion_builder.sv
hw/pcie_axil_bridge.sv
tests/tb_pcie_axil_bridge.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_pcie_axil_bridge
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: name, op, bar, pcie addr, first be, tag, requester id, write data,
// expected axi addr, expected status, lower addr, byte count, completion data

localparam logic op_wr = 1'b0;
localparam logic op_rd = 1'b1;

typedef struct packed {
  logic [127:0] name;
  logic         op;
  logic [2:0]   bar;
  logic [63:0]  addr;
  logic [3:0]   be;
  logic [7:0]   tag;
  logic [15:0]  req_id;
  logic [31:0]  wdata;
  logic [31:0]  exp_axi;
  logic [2:0]   exp_status;
  logic [6:0]   exp_la;
  logic [2:0]   exp_bc;
  logic [31:0]  exp_data;
} vec_t;

localparam int n_vec = 15;

// Memory fill is addr ^ 32'h5a5a_a5a5, SLVERR for reads in 0x3000_fxxx
localparam vec_t vectors [n_vec] = '{
  '{"wr_bar0", op_wr, 3'd0, 64'h0000_0000_fe00_0124, 4'hf, 8'h01, 16'h0100,
    32'h1111_1111, 32'h6000_0124, cpl_sc, 7'h00, 3'd0, 32'h0},
  '{"wr_bar1", op_wr, 3'd1, 64'h0000_0001_0001_2348, 4'h3, 8'h02, 16'h0100,
    32'h2222_3333, 32'h5000_2348, cpl_sc, 7'h00, 3'd0, 32'h0},
  '{"wr_bar2", op_wr, 3'd2, 64'h0000_0000_0000_0abc, 4'hc, 8'h03, 16'h0100,
    32'h4444_5555, 32'h4000_02bc, cpl_sc, 7'h00, 3'd0, 32'h0},
  '{"wr_bar3", op_wr, 3'd3, 64'h0000_0000_0012_3450, 4'hf, 8'h04, 16'h0100,
    32'h6666_7777, 32'h3002_3450, cpl_sc, 7'h00, 3'd0, 32'h0},
  '{"wr_bar4", op_wr, 3'd4, 64'h0000_0000_1234_56f8, 4'hf, 8'h05, 16'h0100,
    32'h8888_9999, 32'h2000_00f8, cpl_sc, 7'h00, 3'd0, 32'h0},
  '{"wr_bar5_ur", op_wr, 3'd5, 64'h0000_0000_0000_0100, 4'hf, 8'h06, 16'h0100,
    32'hdead_0001, 32'h0, cpl_ur, 7'h00, 3'd0, 32'h0},
  '{"rd_bar0", op_rd, 3'd0, 64'h0000_0000_0000_0a40, 4'hf, 8'h11, 16'h0200,
    32'h0, 32'h6000_0a40, cpl_sc, 7'h40, 3'd4, 32'h3a5a_afe5},
  '{"rd_be_0001", op_rd, 3'd1, 64'h0000_0000_0000_7004, 4'h1, 8'h2a, 16'h0203,
    32'h0, 32'h5000_7004, cpl_sc, 7'h04, 3'd1, 32'h0a5a_d5a1},
  '{"rd_be_0110", op_rd, 3'd2, 64'h0000_0000_0000_0108, 4'h6, 8'h33, 16'h0204,
    32'h0, 32'h4000_0108, cpl_sc, 7'h09, 3'd2, 32'h1a5a_a4ad},
  '{"rd_be_1100", op_rd, 3'd3, 64'h0000_0000_0000_0014, 4'hc, 8'h3c, 16'h0205,
    32'h0, 32'h3000_0014, cpl_sc, 7'h16, 3'd2, 32'h6a5a_a5b1},
  '{"rd_be_0000", op_rd, 3'd4, 64'h0000_0000_0000_0071, 4'h0, 8'h25, 16'h0206,
    32'h0, 32'h2000_0070, cpl_sc, 7'h70, 3'd1, 32'h7a5a_a5d5},
  '{"rd_bar5_ur", op_rd, 3'd5, 64'h0000_0000_0000_0200, 4'hf, 8'h3f, 16'h0207,
    32'h0, 32'h0, cpl_ur, 7'h00, 3'd4, 32'h0},
  '{"rd_slverr", op_rd, 3'd3, 64'h0000_0000_0000_f020, 4'hf, 8'h16, 16'h0208,
    32'h0, 32'h3000_f020, cpl_ca, 7'h20, 3'd4, 32'h0},
  '{"rd_bar0_back", op_rd, 3'd0, 64'h0000_0000_0000_0124, 4'hf, 8'h07, 16'h0209,
    32'h0, 32'h6000_0124, cpl_sc, 7'h24, 3'd4, 32'h1111_1111},
  '{"rd_bar1_merge", op_rd, 3'd1, 64'h0000_0000_0000_2348, 4'hf, 8'h08, 16'h020a,
    32'h0, 32'h5000_2348, cpl_sc, 7'h48, 3'd4, 32'h0a5a_3333}
};

`endif

// File: tests/tb_pcie_axil_bridge.sv
`timescale 1ns/1ns

module tb_pcie_axil_bridge import pcie_axil_pkg::*; ();

  `include "tb_vectors.svh"

  localparam int wait_limit  = 500;
  localparam int stress_reqs = 16;

  logic      axi_clk = 1'b0;
  logic      axi_aresetn;
  logic      cq_valid;
  cq_req_t   cq_req;
  logic      cq_ready;
  axil_m2s_t m_axil;
  axil_s2m_t s_axil;
  logic      cc_valid;
  logic      cc_ready;
  cc_cpl_t   cc_cpl;

  logic [31:0] rng_state = 32'h3ea6;
  logic [31:0] stall_rng = 32'h3ea6;
  logic        saw_backpressure = 1'b0;

  // Slave model state
  logic [31:0] mem [logic [31:0]];
  logic        aw_have;
  logic        w_have;
  logic        ar_have;
  logic        b_done;
  logic        r_done;
  logic [31:0] aw_addr_q;
  logic [31:0] w_data_q;
  logic [31:0] ar_addr_q;
  logic [3:0]  w_strb_q;
  logic [31:0] last_awaddr;
  logic [31:0] last_wdata;
  logic [31:0] last_araddr;
  logic [3:0]  last_wstrb;
  logic [2:0]  last_awprot;
  logic [2:0]  last_arprot;
  int          aw_count = 0;
  int          ar_count = 0;
  int          b_count = 0;
  int          exp_aw = 0;
  int          exp_ar = 0;

  pcie_axil_bridge uut (
    .axi_clk     (axi_clk),
    .axi_aresetn (axi_aresetn),
    .cq_valid    (cq_valid),
    .cq_req      (cq_req),
    .cq_ready    (cq_ready),
    .m_axil      (m_axil),
    .s_axil      (s_axil),
    .cc_valid    (cc_valid),
    .cc_ready    (cc_ready),
    .cc_cpl      (cc_cpl)
  );

  always #5 axi_clk = ~axi_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] mem_fill(input logic [31:0] a);
    return a ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] slave_read(input logic [31:0] a);
    if (mem.exists(a))
      return mem[a];
    return mem_fill(a);
  endfunction

  task automatic report_mismatch(input string test, input string field,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %s %s expected %0h actual %0h", test, field, exp, act);
    $display("=== FAIL ===");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_problem(input string what);
    $display("Error: %s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else report_mismatch(test, field, exp, act);
  endtask

  //////////////////////////////////////////////////
  // AXI-Lite slave with random delays
  //////////////////////////////////////////////////

  always begin
    logic [31:0] rnd;
    logic [31:0] merged;
    @(posedge axi_clk);
    if (!axi_aresetn) begin
      aw_have = 1'b0;
      w_have  = 1'b0;
      ar_have = 1'b0;
      b_done  = 1'b0;
      r_done  = 1'b0;
    end else begin
      if (m_axil.awvalid && s_axil.awready) begin
        aw_have     = 1'b1;
        aw_addr_q   = m_axil.awaddr;
        last_awprot = m_axil.awprot;
        aw_count++;
      end
      if (m_axil.wvalid && s_axil.wready) begin
        w_have   = 1'b1;
        w_data_q = m_axil.wdata;
        w_strb_q = m_axil.wstrb;
      end
      if (m_axil.arvalid && s_axil.arready) begin
        ar_have     = 1'b1;
        ar_addr_q   = m_axil.araddr;
        last_araddr = m_axil.araddr;
        last_arprot = m_axil.arprot;
        ar_count++;
      end
      b_done = s_axil.bvalid && m_axil.bready;
      r_done = s_axil.rvalid && m_axil.rready;
    end
    #1;
    if (axi_aresetn) begin
      rnd = next_rand();
      if (b_done) begin
        s_axil.bvalid = 1'b0;
        b_count++;
      end
      if (r_done)
        s_axil.rvalid = 1'b0;
      s_axil.awready = !aw_have && rnd[0];
      s_axil.wready  = !w_have && rnd[1];
      if (aw_have && w_have && !s_axil.bvalid && rnd[2]) begin
        merged = slave_read(aw_addr_q);
        for (int i = 0; i < 4; i++)
          if (w_strb_q[i])
            merged[8*i +: 8] = w_data_q[8*i +: 8];
        mem[aw_addr_q] = merged;
        last_awaddr    = aw_addr_q;
        last_wdata     = w_data_q;
        last_wstrb     = w_strb_q;
        s_axil.bvalid  = 1'b1;
        s_axil.bresp   = 2'b00;
        aw_have        = 1'b0;
        w_have         = 1'b0;
      end
      s_axil.arready = !ar_have && !s_axil.rvalid && rnd[3];
      if (ar_have && !s_axil.rvalid && rnd[4]) begin
        s_axil.rvalid = 1'b1;
        s_axil.rdata  = slave_read(ar_addr_q);
        // SLVERR window in BAR 3
        s_axil.rresp  = (ar_addr_q[31:12] == 20'h3000f) ? 2'b10 : 2'b00;
        ar_have       = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Request driver and waits
  //////////////////////////////////////////////////

  // Starts 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic send_request(input cq_req_t req);
    int  waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    cq_valid = 1'b1;
    cq_req   = req;
    while (!accepted) begin
      @(posedge axi_clk);
      if (cq_ready) begin
        accepted = 1'b1;
      end else begin
        saw_backpressure = 1'b1;
        waited++;
        if (waited > wait_limit)
          report_problem("timed out waiting for cq_ready");
      end
    end
    #1;
    cq_valid = 1'b0;
  endtask

  task automatic wait_write_done(input int count);
    int waited;
    waited = 0;
    while (b_count < count) begin
      @(posedge axi_clk);
      waited++;
      if (waited > wait_limit)
        report_problem("timed out waiting for the AXI write response");
    end
    #1;
  endtask

  // Returns 1 ns after the edge that takes the completion
  task automatic wait_completion(output cc_cpl_t cpl);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(posedge axi_clk);
      if (cc_valid) begin
        seen = 1'b1;
        cpl  = cc_cpl;
      end else begin
        waited++;
        if (waited > wait_limit)
          report_problem("timed out waiting for cc_valid");
      end
    end
    #1;
  endtask

  task automatic run_vector(input vec_t v);
    cq_req_t req;
    cc_cpl_t cpl;
    string   nm;
    nm           = $sformatf("%0s", v.name);
    req.bar_hit  = v.bar;
    req.addr     = v.addr;
    req.first_be = v.be;
    req.write    = (v.op == op_wr);
    req.req_id   = v.req_id;
    req.tag      = v.tag;
    req.tc       = v.tag[2:0];
    req.attr     = v.tag[5:3];
    req.data     = v.wdata;
    send_request(req);
    if (v.op == op_wr && v.exp_status == cpl_ur) begin
      // Later reads check that no AW occurred
    end else if (v.op == op_wr) begin
      exp_aw++;
      wait_write_done(exp_aw);
      check_value(nm, "awaddr", v.exp_axi, last_awaddr);
      check_value(nm, "awprot", 3'b000, last_awprot);
      check_value(nm, "wdata", v.wdata, last_wdata);
      check_value(nm, "wstrb", v.be, last_wstrb);
      check_value(nm, "aw count", exp_aw, aw_count);
    end else begin
      if (v.exp_status != cpl_ur)
        exp_ar++;
      wait_completion(cpl);
      check_value(nm, "status", v.exp_status, cpl.status);
      check_value(nm, "lower addr", v.exp_la, cpl.lower_addr);
      check_value(nm, "byte count", v.exp_bc, cpl.byte_count);
      check_value(nm, "tag", v.tag, cpl.tag);
      check_value(nm, "requester id", v.req_id, cpl.req_id);
      check_value(nm, "tc", v.tag[2:0], cpl.tc);
      check_value(nm, "attr", v.tag[5:3], cpl.attr);
      check_value(nm, "data", v.exp_data, cpl.data);
      check_value(nm, "ar count", exp_ar, ar_count);
      check_value(nm, "aw count", exp_aw, aw_count);
      if (v.exp_status != cpl_ur) begin
        check_value(nm, "araddr", v.exp_axi, last_araddr);
        check_value(nm, "arprot", 3'b000, last_arprot);
      end
    end
  endtask

  // In-order completions under random cc_ready stalls
  task automatic collect_stress();
    int          cycles;
    int          got;
    logic        held_valid;
    cc_cpl_t     held_cpl;
    logic [31:0] r;
    cycles     = 0;
    got        = 0;
    held_valid = 1'b0;
    while (got < stress_reqs) begin
      @(posedge axi_clk);
      cycles++;
      if (cycles > 20 * wait_limit)
        report_problem("timed out collecting stressed completions");
      if (held_valid) begin
        assert (cc_valid && cc_cpl === held_cpl)
          else report_problem("completion changed while cc_ready was low");
      end
      held_valid = cc_valid && !cc_ready;
      held_cpl   = cc_cpl;
      if (cc_valid && cc_ready) begin
        check_value("stress", "tag", 8'h80 + got, cc_cpl.tag);
        check_value("stress", "status", cpl_sc, cc_cpl.status);
        check_value("stress", "data", mem_fill(32'h4000_0100 + 4 * got), cc_cpl.data);
        got++;
      end
      #1;
      stall_rng = xorshift32(stall_rng);
      r         = stall_rng;
      cc_ready  = (cycles > 40) && (r[1:0] != 2'b00);
    end
  endtask

  initial begin
    cq_req_t req;
    axi_aresetn = 1'b0;
    cq_valid    = 1'b0;
    cq_req      = '0;
    cc_ready    = 1'b1;
    s_axil      = '0;
    repeat (4) @(posedge axi_clk);
    #1;
    axi_aresetn = 1'b1;

    for (int i = 0; i < n_vec; i++)
      run_vector(vectors[i]);

    cc_ready         = 1'b0;
    saw_backpressure = 1'b0;
    fork
      begin
        for (int k = 0; k < stress_reqs; k++) begin
          req          = '0;
          req.bar_hit  = 3'd2;
          req.addr     = 64'h100 + 4 * k;
          req.first_be = 4'hf;
          req.tag      = 8'h80 + 8'(k);
          req.req_id   = 16'h0300;
          send_request(req);
        end
      end
      collect_stress();
    join
    assert (saw_backpressure) else report_problem("cq_ready never dropped under stall");
    check_value("stress", "ar count", exp_ar + stress_reqs, ar_count);
    check_value("final", "aw count", exp_aw, aw_count);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: hw/pcie_axil_bridge.sv
`timescale 1ns/1ns

module pcie_axil_bridge import pcie_axil_pkg::*; (
  input  logic      axi_clk,
  input  logic      axi_aresetn,
  input  logic      cq_valid,
  input  cq_req_t   cq_req,
  output logic      cq_ready,
  output axil_m2s_t m_axil,
  input  axil_s2m_t s_axil,
  output logic      cc_valid,
  input  logic      cc_ready,
  output cc_cpl_t   cc_cpl
);

  // Request path
  logic       req_push;
  axi_req_t   req_in;
  logic       req_full;
  logic       req_pop;
  axi_req_t   req_out;
  logic       req_empty;

  // Outstanding read records
  logic       rec_push;
  rd_record_t rec_in;
  logic       rec_full;
  logic       rec_pop;
  rd_record_t rec_out;
  logic       rec_empty;

  logic       rd_valid;
  logic       rd_ready;
  rd_result_t rd_result;

  cq_request_decoder u_decoder (
    .cq_valid (cq_valid),
    .cq_req   (cq_req),
    .cq_ready (cq_ready),
    .req_push (req_push),
    .req_data (req_in),
    .req_full (req_full),
    .rec_push (rec_push),
    .rec_data (rec_in),
    .rec_full (rec_full)
  );

  sync_fifo #(
    .payload_t (axi_req_t),
    .depth     (fifo_depth)
  ) req_fifo (
    .axi_clk     (axi_clk),
    .axi_aresetn (axi_aresetn),
    .push        (req_push),
    .push_data   (req_in),
    .full        (req_full),
    .pop         (req_pop),
    .pop_data    (req_out),
    .empty       (req_empty)
  );

  sync_fifo #(
    .payload_t (rd_record_t),
    .depth     (fifo_depth)
  ) rec_fifo (
    .axi_clk     (axi_clk),
    .axi_aresetn (axi_aresetn),
    .push        (rec_push),
    .push_data   (rec_in),
    .full        (rec_full),
    .pop         (rec_pop),
    .pop_data    (rec_out),
    .empty       (rec_empty)
  );

  axil_master u_master (
    .axi_clk     (axi_clk),
    .axi_aresetn (axi_aresetn),
    .req_data    (req_out),
    .req_empty   (req_empty),
    .req_pop     (req_pop),
    .m_axil      (m_axil),
    .s_axil      (s_axil),
    .rd_valid    (rd_valid),
    .rd_ready    (rd_ready),
    .rd_result   (rd_result)
  );

  completion_builder u_builder (
    .axi_clk     (axi_clk),
    .axi_aresetn (axi_aresetn),
    .rec_data    (rec_out),
    .rec_empty   (rec_empty),
    .rec_pop     (rec_pop),
    .rd_valid    (rd_valid),
    .rd_result   (rd_result),
    .rd_ready    (rd_ready),
    .cc_valid    (cc_valid),
    .cc_ready    (cc_ready),
    .cc_cpl      (cc_cpl)
  );

endmodule

// File: hw/completion_builder.sv
`timescale 1ns/1ns

module completion_builder import pcie_axil_pkg::*; (
  input  logic       axi_clk,
  input  logic       axi_aresetn,
  input  rd_record_t rec_data,
  input  logic       rec_empty,
  output logic       rec_pop,
  input  logic       rd_valid,
  input  rd_result_t rd_result,
  output logic       rd_ready,
  output logic       cc_valid,
  input  logic       cc_ready,
  output cc_cpl_t    cc_cpl
);

  logic       cc_valid_q;
  cc_cpl_t    cc_cpl_q;
  logic       slot_free;
  logic       take;
  logic [2:0] status;

  // Span from first to last enabled byte
  function automatic logic [2:0] byte_count(input logic [3:0] be);
    int first;
    int last;
    first = 0;
    last  = 0;
    for (int i = 3; i >= 0; i--)
      if (be[i])
        first = i;
    for (int i = 0; i < 4; i++)
      if (be[i])
        last = i;
    return 3'(last - first + 1);
  endfunction

  assign slot_free = !cc_valid_q || cc_ready;

  // UR records complete without waiting on AXI
  assign take     = slot_free && !rec_empty && (rec_data.ur || rd_valid);
  assign rec_pop  = take;
  assign rd_ready = take && !rec_data.ur;

  always_comb begin
    if (rec_data.ur)
      status = cpl_ur;
    else if (rd_result.resp != axi_resp_okay)
      status = cpl_ca;
    else
      status = cpl_sc;
  end

  always_ff @(posedge axi_clk) begin
    if (take) begin
      cc_cpl_q.status     <= status;
      cc_cpl_q.lower_addr <= rec_data.lower_addr;
      cc_cpl_q.byte_count <= byte_count(rec_data.first_be);
      cc_cpl_q.req_id     <= rec_data.req_id;
      cc_cpl_q.tag        <= rec_data.tag;
      cc_cpl_q.tc         <= rec_data.tc;
      cc_cpl_q.attr       <= rec_data.attr;
      cc_cpl_q.data       <= (status == cpl_sc) ? rd_result.data : '0;
    end
  end

  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      cc_valid_q <= 1'b0;
    end else begin
      if (take)
        cc_valid_q <= 1'b1;
      else if (cc_ready)
        cc_valid_q <= 1'b0;
    end
  end

  assign cc_valid = cc_valid_q;
  assign cc_cpl   = cc_cpl_q;

endmodule

// File: hw/axil_master.sv
`timescale 1ns/1ns

module axil_master import pcie_axil_pkg::*; (
  input  logic       axi_clk,
  input  logic       axi_aresetn,
  input  axi_req_t   req_data,
  input  logic       req_empty,
  output logic       req_pop,
  output axil_m2s_t  m_axil,
  input  axil_s2m_t  s_axil,
  output logic       rd_valid,
  input  logic       rd_ready,
  output rd_result_t rd_result
);

  typedef enum logic [2:0] {
    st_idle,
    st_write,
    st_wr_resp,
    st_read,
    st_rd_hold
  } state_t;

  state_t                state;
  logic [axi_addr_w-1:0] addr_q;
  logic [data_w-1:0]     wdata_q;
  logic [data_w/8-1:0]   wstrb_q;
  logic                  awvalid_q;
  logic                  wvalid_q;
  logic                  arvalid_q;
  logic                  aw_done;
  logic                  w_done;

  // Base bits from the BAR table, offset bits from the request
  function automatic logic [axi_addr_w-1:0] xlate_addr(
    input logic [2:0]             bar,
    input logic [pcie_addr_w-1:0] addr
  );
    logic [axi_addr_w-1:0] mask;
    logic [axi_addr_w-1:0] full_addr;
    mask      = (axi_addr_w'(1) << bar_aperture_bits[bar]) - 1'b1;
    full_addr = (bar_xlate[bar] & ~mask) | (addr[axi_addr_w-1:0] & mask);
    return {full_addr[axi_addr_w-1:2], 2'b00};
  endfunction

  assign req_pop  = (state == st_idle) && !req_empty;
  assign aw_done  = !awvalid_q || s_axil.awready;
  assign w_done   = !wvalid_q || s_axil.wready;
  assign rd_valid = (state == st_rd_hold);

  always_comb begin
    m_axil.awaddr  = addr_q;
    m_axil.awprot  = 3'b000;
    m_axil.awvalid = awvalid_q;
    m_axil.wdata   = wdata_q;
    m_axil.wstrb   = wstrb_q;
    m_axil.wvalid  = wvalid_q;
    m_axil.bready  = (state == st_wr_resp);
    m_axil.araddr  = addr_q;
    m_axil.arprot  = 3'b000;
    m_axil.arvalid = arvalid_q;
    m_axil.rready  = (state == st_read);
  end

  always_ff @(posedge axi_clk) begin
    if (req_pop) begin
      addr_q  <= xlate_addr(req_data.bar_hit, req_data.addr);
      wdata_q <= req_data.data;
      wstrb_q <= req_data.first_be;
    end
    if (state == st_read && s_axil.rvalid)
      rd_result <= '{data: s_axil.rdata, resp: s_axil.rresp};
  end

  //////////////////////////////////////////////////
  // Channel FSM, one transaction at a time
  //////////////////////////////////////////////////

  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state     <= st_idle;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_pop && req_data.write) begin
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
            state     <= st_write;
          end else if (req_pop) begin
            arvalid_q <= 1'b1;
            state     <= st_read;
          end
        end
        st_write: begin
          if (s_axil.awready)
            awvalid_q <= 1'b0;
          if (s_axil.wready)
            wvalid_q <= 1'b0;
          if (aw_done && w_done)
            state <= st_wr_resp;
        end
        st_wr_resp: begin
          if (s_axil.bvalid)
            state <= st_idle;
        end
        st_read: begin
          if (s_axil.arready)
            arvalid_q <= 1'b0;
          if (s_axil.rvalid)
            state <= st_rd_hold;
        end
        st_rd_hold: begin
          if (rd_ready)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: hw/cq_request_decoder.sv
`timescale 1ns/1ns

module cq_request_decoder import pcie_axil_pkg::*; (
  input  logic       cq_valid,
  input  cq_req_t    cq_req,
  output logic       cq_ready,
  output logic       req_push,
  output axi_req_t   req_data,
  input  logic       req_full,
  output logic       rec_push,
  output rd_record_t rec_data,
  input  logic       rec_full
);

  logic       bar_ok;
  logic       accept;
  logic [1:0] be_offset;

  // BAR hits beyond the table are never enabled
  always_comb begin
    bar_ok = 1'b0;
    if (cq_req.bar_hit < num_bars)
      bar_ok = bar_enable[cq_req.bar_hit];
  end

  // Offset of first enabled byte
  always_comb begin
    casez (cq_req.first_be)
      4'b???1: be_offset = 2'd0;
      4'b??10: be_offset = 2'd1;
      4'b?100: be_offset = 2'd2;
      4'b1000: be_offset = 2'd3;
      default: be_offset = 2'd0;
    endcase
  end

  assign cq_ready = !req_full && !rec_full;
  assign accept   = cq_valid && cq_ready;

  // Unsupported writes are accepted here and go nowhere
  assign req_push = accept && bar_ok;
  assign rec_push = accept && !cq_req.write;

  always_comb begin
    req_data.bar_hit  = cq_req.bar_hit;
    req_data.addr     = cq_req.addr;
    req_data.first_be = cq_req.first_be;
    req_data.write    = cq_req.write;
    req_data.data     = cq_req.data;
  end

  always_comb begin
    rec_data.req_id     = cq_req.req_id;
    rec_data.tag        = cq_req.tag;
    rec_data.tc         = cq_req.tc;
    rec_data.attr       = cq_req.attr;
    rec_data.lower_addr = {cq_req.addr[6:2], be_offset};
    rec_data.first_be   = cq_req.first_be;
    rec_data.ur         = !bar_ok;
  end

endmodule

// File: hw/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo import pcie_axil_pkg::*; #(
  parameter type payload_t = logic,
  parameter int  depth     = fifo_depth
) (
  input  logic     axi_clk,
  input  logic     axi_aresetn,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign full     = (count == cnt_w'(depth));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge axi_clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap at depth, not at a power of two
  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: hw/pcie_axil_pkg.sv
package pcie_axil_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////

  localparam int axi_addr_w  = 32;
  localparam int data_w      = 32;
  localparam int pcie_addr_w = 64;
  localparam int num_bars    = 6;
  localparam int fifo_depth  = 8;

  //////////////////////////////////////////////////
  // BAR tables
  //////////////////////////////////////////////////

  // BAR 5 not decoded
  localparam logic [num_bars-1:0] bar_enable = 6'b01_1111;

  localparam logic [axi_addr_w-1:0] bar_xlate [num_bars] = '{
    32'h6000_0000,
    32'h5000_0000,
    32'h4000_0000,
    32'h3000_0000,
    32'h2000_0000,
    32'h1000_0000
  };

  // log2 of aperture size per BAR
  localparam int bar_aperture_bits [num_bars] = '{12, 16, 10, 20, 8, 12};

  // Completion status
  localparam logic [2:0] cpl_sc = 3'b000;
  localparam logic [2:0] cpl_ur = 3'b001;
  localparam logic [2:0] cpl_ca = 3'b100;

  localparam logic [1:0] axi_resp_okay = 2'b00;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [2:0]             bar_hit;
    logic [pcie_addr_w-1:0] addr;
    logic [3:0]             first_be;
    logic                   write;
    logic [15:0]            req_id;
    logic [7:0]             tag;
    logic [2:0]             tc;
    logic [2:0]             attr;
    logic [data_w-1:0]      data;
  } cq_req_t;

  typedef struct packed {
    logic [2:0]             bar_hit;
    logic [pcie_addr_w-1:0] addr;
    logic [3:0]             first_be;
    logic                   write;
    logic [data_w-1:0]      data;
  } axi_req_t;

  typedef struct packed {
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [2:0]  tc;
    logic [2:0]  attr;
    logic [6:0]  lower_addr;
    logic [3:0]  first_be;
    logic        ur;
  } rd_record_t;

  typedef struct packed {
    logic [2:0]        status;
    logic [6:0]        lower_addr;
    logic [2:0]        byte_count;
    logic [15:0]       req_id;
    logic [7:0]        tag;
    logic [2:0]        tc;
    logic [2:0]        attr;
    logic [data_w-1:0] data;
  } cc_cpl_t;

  typedef struct packed {
    logic [axi_addr_w-1:0] awaddr;
    logic [2:0]            awprot;
    logic                  awvalid;
    logic [data_w-1:0]     wdata;
    logic [data_w/8-1:0]   wstrb;
    logic                  wvalid;
    logic                  bready;
    logic [axi_addr_w-1:0] araddr;
    logic [2:0]            arprot;
    logic                  arvalid;
    logic                  rready;
  } axil_m2s_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              arready;
    logic [data_w-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
  } axil_s2m_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [1:0]        resp;
  } rd_result_t;

endpackage
